/* Bender.yml */
package:
  name: crc5_link

sources:
  - logic/crc5_pkg.sv
  - logic/crc5_step_if.sv
  - logic/crc5_ctrl.sv
  - logic/bit_counter.sv
  - logic/crc5_shifter.sv
  - logic/crc5_compare.sv
  - logic/crc5_link.sv
  - target: simulation
    files:
      - bench/crc5_link_tb.sv

/* bench/crc5_link_tb.sv */
`timescale 1ns/1ps

module crc5_link_tb;

	import crc5_pkg::*;

	localparam int NUM_FIXED  = 8;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_FRAMES = NUM_FIXED + NUM_RANDOM;
	localparam int MAX_BYTES  = 8;
	localparam int MAX_EXTRA  = 3;                   // Largest idle gap from two LFSR bits
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic      sys_clk;
	logic      sys_rst;
	logic      txrx_en;
	logic      txrx_data_valid;
	crc_byte_t txrx_data;
	logic      txrx_last_byte;
	crc5_t     txrx_rx_crc;
	crc5_t     txrx_crc_value;
	logic      txrx_crc_valid;
	logic      txrx_crc_ok;

	// Frame table of length, bytes, corrupt CRC flag, enable drop point and expected CRC
	int        frame_len     [NUM_FRAMES];
	crc_byte_t frame_data    [NUM_FRAMES][MAX_BYTES];
	bit        frame_corrupt [NUM_FRAMES];
	int        frame_drop    [NUM_FRAMES];      // First byte after the restart or zero for no drop
	crc5_t     frame_exp     [NUM_FRAMES];

	logic [31:0] lfsr_state;
	int          valid_count;
	int          cycle_count;
	int          timeout_cycles;

	crc5_link u_crc5_link
	(
		.i_sys_clk         (sys_clk),
		.i_sys_rst         (sys_rst),
		.i_txrx_en         (txrx_en),
		.i_txrx_data_valid (txrx_data_valid),
		.i_txrx_data       (txrx_data),
		.i_txrx_last_byte  (txrx_last_byte),
		.i_txrx_rx_crc     (txrx_rx_crc),
		.o_txrx_crc_value  (txrx_crc_value),
		.o_txrx_crc_valid  (txrx_crc_valid),
		.o_txrx_crc_ok     (txrx_crc_ok)
	);

	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] value;
		logic        out_bit;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			out_bit    = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit)
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			value = {value[30:0], out_bit};
		end
		return value;
	endfunction

	// Bitwise CRC over x^5 + x^2 + 1 taking the byte MSB first
	function automatic crc5_t crc_update(input crc5_t crc, input crc_byte_t data);
		logic fb;
		for (int i = 7; i >= 0; i--)
		begin
			fb  = data[i] ^ crc[4];
			crc = {crc[3:0], 1'b0};
			if (fb)
				crc = crc ^ 5'b00101;
		end
		return crc;
	endfunction

	task automatic check_equal(input string sig, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp)
		else
		begin
			$display("MISMATCH at %0t: %s expected %0h got %0h", $time, sig, exp, got);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// Outputs settle at the edge and inputs change 2 ns later
	task automatic tick();
		@(posedge sys_clk);
		#2;
		if (txrx_crc_valid === 1'b1)
			valid_count = valid_count + 1;
	endtask

	task automatic set_frame(input int idx, input int len, input logic [63:0] bytes,
		input bit corrupt, input int drop);
		frame_len[idx]     = len;
		frame_corrupt[idx] = corrupt;
		frame_drop[idx]    = drop;
		for (int j = 0; j < MAX_BYTES; j++)
			frame_data[idx][j] = bytes[63-8*j -: 8];
	endtask

	task automatic build_table();
		int sum;
		crc5_t crc;
		set_frame(0, 1, 64'h00_00000000000000, 1'b0, 0);
		set_frame(1, 1, 64'hA5_00000000000000, 1'b1, 0);
		set_frame(2, 4, 64'hDEADBEEF_00000000, 1'b0, 0);
		set_frame(3, 4, 64'hDEADBEEF_00000000, 1'b0, 0);   // Same frame again from the seed
		set_frame(4, 3, 64'h123456_0000000000, 1'b1, 0);
		set_frame(5, 5, 64'h0102030405_000000, 1'b0, 2);
		set_frame(6, 8, 64'hFFFFFFFFFFFFFFFF, 1'b0, 0);
		set_frame(7, 6, 64'h3C5A96C3E718_0000, 1'b1, 1);
		for (int f = NUM_FIXED; f < NUM_FRAMES; f++)
		begin
			frame_len[f]     = 1 + int'(draw_bits(3));
			frame_corrupt[f] = 1'(draw_bits(1));
			frame_drop[f]    = 0;
			for (int j = 0; j < MAX_BYTES; j++)
				frame_data[f][j] = crc_byte_t'(draw_bits(8));
		end
		sum = 0;
		for (int f = 0; f < NUM_FRAMES; f++)
		begin
			crc = CRC5_SEED;
			for (int j = frame_drop[f]; j < frame_len[f]; j++)
				crc = crc_update(crc, frame_data[f][j]);
			frame_exp[f] = crc;
			sum = sum + frame_len[f] * (MIN_BYTE_GAP + MAX_EXTRA) + 12;
		end
		timeout_cycles = 2 * sum + 16 + 100;
	endtask

	task automatic run_frame(input int idx);
		int    start_count;
		int    extra;
		crc5_t rx_crc;
		start_count = valid_count;
		for (int j = 0; j < frame_len[idx]; j++)
		begin
			extra = int'(draw_bits(2));
			repeat (extra) tick();
			txrx_data_valid = 1'b1;
			txrx_data       = frame_data[idx][j];
			tick();
			txrx_data_valid = 1'b0;
			txrx_data       = ~frame_data[idx][j];
			if (frame_drop[idx] != 0 && j == frame_drop[idx] - 1)
			begin
				repeat (3) tick();                      // Part way through the shift
				txrx_en = 1'b0;
				repeat (2) tick();
				txrx_en = 1'b1;
				tick();
			end
			else
				repeat (MIN_BYTE_GAP - 1) tick();
		end
		rx_crc = frame_exp[idx];
		if (frame_corrupt[idx])
			rx_crc = rx_crc ^ (5'b00001 << (draw_bits(3) % 5));
		txrx_last_byte = 1'b1;
		txrx_rx_crc    = rx_crc;
		tick();
		txrx_last_byte = 1'b0;
		txrx_rx_crc    = ~rx_crc;
		check_equal("o_txrx_crc_valid", 1'b0, txrx_crc_valid);
		tick();
		check_equal("o_txrx_crc_valid", 1'b1, txrx_crc_valid);
		check_equal("o_txrx_crc_value", frame_exp[idx], txrx_crc_value);
		check_equal("o_txrx_crc_ok", !frame_corrupt[idx], txrx_crc_ok);
		tick();
		check_equal("o_txrx_crc_valid", 1'b0, txrx_crc_valid);
		check_equal("o_txrx_crc_value", frame_exp[idx], txrx_crc_value);
		check_equal("o_txrx_crc_valid pulse count", 1, valid_count - start_count);
	endtask

	initial
	begin
		sys_clk         = 1'b0;
		sys_rst         = 1'b0;
		txrx_en         = 1'b0;
		txrx_data_valid = 1'b0;
		txrx_data       = '0;
		txrx_last_byte  = 1'b0;
		txrx_rx_crc     = '0;
		lfsr_state      = 32'he0e3;
		valid_count     = 0;
		cycle_count     = 0;
		build_table();

		repeat (16) @(posedge sys_clk);
		#2;
		sys_rst = 1'b1;
		txrx_en = 1'b1;
		tick();
		check_equal("o_txrx_crc_valid", 1'b0, txrx_crc_valid);
		check_equal("o_txrx_crc_ok", 1'b0, txrx_crc_ok);
		check_equal("o_txrx_crc_value", 5'd0, txrx_crc_value);

		for (int f = 0; f < NUM_FRAMES; f++)
			run_frame(f);

		repeat (4) tick();
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* crc5_link.f */
logic/crc5_pkg.sv
logic/crc5_step_if.sv
logic/crc5_ctrl.sv
logic/bit_counter.sv
logic/crc5_shifter.sv
logic/crc5_compare.sv
logic/crc5_link.sv
bench/crc5_link_tb.sv

/* logic/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter
(
	input  logic      i_sys_clk,
	input  logic      i_sys_rst,
	crc5_step_if.cnt  step
);

	import crc5_pkg::*;

	bit_idx_t count_q;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			count_q <= '0;
		else if (step.load)
			count_q <= '0;
		else if (step.shift)
			count_q <= count_q + 1'b1;                  // Wraps to 0 after the eighth step
	end

	assign step.bit_idx  = count_q;
	assign step.last_bit = step.shift && (count_q == bit_idx_t'(BYTE_BITS - 1));

	// The controller must drop shift right after the last step
	property p_no_wrap;
		@(posedge i_sys_clk) disable iff (!i_sys_rst)
			step.last_bit |=> !step.shift;
	endproperty

	a_no_wrap: assert property (p_no_wrap)
		else $error("Shift still active after bit 7");

endmodule

/* logic/crc5_compare.sv */
`timescale 1ns/1ps

module crc5_compare
(
	input  logic            i_sys_clk,
	input  logic            i_sys_rst,
	input  logic            i_report,
	input  crc5_pkg::crc5_t i_remainder,
	input  logic            i_last_byte,
	input  crc5_pkg::crc5_t i_rx_crc,
	output crc5_pkg::crc5_t o_crc_value,
	output logic            o_crc_valid,
	output logic            o_crc_ok
);

	import crc5_pkg::*;

	crc5_t rx_crc_q;

	always_ff @(posedge i_sys_clk)
	begin
		if (i_last_byte)
			rx_crc_q <= i_rx_crc;                       // Expected CRC comes with the strobe
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_crc_value <= '0;
			o_crc_valid <= 1'b0;
			o_crc_ok    <= 1'b0;
		end
		else
		begin
			o_crc_valid <= i_report;
			if (i_report)
			begin
				o_crc_value <= i_remainder;               // Held until the next report
				o_crc_ok    <= (i_remainder == rx_crc_q);
			end
		end
	end

	// Valid lands exactly two edges after the last-byte strobe
	property p_valid_timing;
		@(posedge i_sys_clk) disable iff (!i_sys_rst)
			o_crc_valid |-> $past(i_last_byte, 2) && !$past(o_crc_valid);
	endproperty

	a_valid_timing: assert property (p_valid_timing)
		else $error("CRC valid not tied to a last-byte strobe");

endmodule

/* logic/crc5_ctrl.sv */
`timescale 1ns/1ps

module crc5_ctrl
(
	input  logic             i_sys_clk,
	input  logic             i_sys_rst,
	input  logic             i_en,
	input  logic             i_data_valid,
	input  logic             i_last_byte,
	crc5_step_if.ctrl        step,
	output logic             o_report
);

	import crc5_pkg::*;

	crc5_state_e state_q;
	crc5_state_e state_d;
	logic        accept;

	// A byte is taken only between bytes, never mid-shift
	assign accept = i_en && i_data_valid &&
		((state_q == ST_IDLE) || (state_q == ST_HOLD));

	assign step.load    = accept;
	assign step.shift   = i_en && (state_q == ST_SHIFT);
	assign step.restart = (state_q == ST_REPORT);     // Fresh seed for the next frame
	assign o_report     = (state_q == ST_REPORT);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE, ST_HOLD:
			begin
				if (accept)
					state_d = ST_SHIFT;
				else if (i_last_byte)
					state_d = ST_REPORT;
			end
			ST_SHIFT:
			begin
				if (step.last_bit)
					state_d = ST_HOLD;
			end
			ST_REPORT:
				state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
		if (!i_en)
			state_d = ST_IDLE;                            // Abort the frame
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// A byte needs its eight shift cycles before any other strobe
	property p_data_gap;
		@(posedge i_sys_clk) disable iff (!i_sys_rst || !i_en)
			accept |=> (!i_data_valid)[*MIN_BYTE_GAP-1];
	endproperty

	property p_last_gap;
		@(posedge i_sys_clk) disable iff (!i_sys_rst || !i_en)
			accept |=> (!i_last_byte)[*MIN_BYTE_GAP-1];
	endproperty

	a_data_gap: assert property (p_data_gap)
		else $error("Data strobe inside the byte gap");

	a_last_gap: assert property (p_last_gap)
		else $error("Last-byte strobe while shifting");

endmodule

/* logic/crc5_link.sv */
`timescale 1ns/1ps

module crc5_link
(
	input  logic                i_sys_clk,
	input  logic                i_sys_rst,
	input  logic                i_txrx_en,
	input  logic                i_txrx_data_valid,
	input  crc5_pkg::crc_byte_t i_txrx_data,
	input  logic                i_txrx_last_byte,
	input  crc5_pkg::crc5_t     i_txrx_rx_crc,
	output crc5_pkg::crc5_t     o_txrx_crc_value,
	output logic                o_txrx_crc_valid,
	output logic                o_txrx_crc_ok
);

	import crc5_pkg::*;

	crc5_t remainder;
	logic  report;

	crc5_step_if step ();

	crc5_ctrl u_ctrl
	(
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_en         (i_txrx_en),
		.i_data_valid (i_txrx_data_valid),
		.i_last_byte  (i_txrx_last_byte),
		.step         (step.ctrl),
		.o_report     (report)
	);

	bit_counter u_bit_counter
	(
		.i_sys_clk (i_sys_clk),
		.i_sys_rst (i_sys_rst),
		.step      (step.cnt)
	);

	crc5_shifter u_shifter
	(
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst   (i_sys_rst),
		.i_en        (i_txrx_en),
		.i_data      (i_txrx_data),
		.step        (step.shf),
		.o_remainder (remainder)
	);

	// Remainder is sampled on the report edge, before the reseed shows
	crc5_compare u_compare
	(
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst   (i_sys_rst),
		.i_report    (report),
		.i_remainder (remainder),
		.i_last_byte (i_txrx_last_byte),
		.i_rx_crc    (i_txrx_rx_crc),
		.o_crc_value (o_txrx_crc_value),
		.o_crc_valid (o_txrx_crc_valid),
		.o_crc_ok    (o_txrx_crc_ok)
	);

endmodule

/* logic/crc5_pkg.sv */
package crc5_pkg;

	localparam int CRC5_WIDTH   = 5;
	localparam int BYTE_BITS    = 8;
	localparam int IDX_BITS     = 3;
	localparam int MIN_BYTE_GAP = 9;                 // Clocks between data strobes

	typedef logic [BYTE_BITS-1:0]  crc_byte_t;
	typedef logic [CRC5_WIDTH-1:0] crc5_t;
	typedef logic [IDX_BITS-1:0]   bit_idx_t;      // 0 selects the byte MSB

	// Taps below the x^5 term of x^5 + x^2 + 1
	localparam crc5_t CRC5_POLY = 5'b00101;
	localparam crc5_t CRC5_SEED = 5'b11111;

	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_SHIFT  = 2'd1,
		ST_HOLD   = 2'd2,
		ST_REPORT = 2'd3
	} crc5_state_e;

endpackage

/* logic/crc5_shifter.sv */
`timescale 1ns/1ps

module crc5_shifter
(
	input  logic                i_sys_clk,
	input  logic                i_sys_rst,
	input  logic                i_en,
	input  crc5_pkg::crc_byte_t i_data,
	crc5_step_if.shf            step,
	output crc5_pkg::crc5_t     o_remainder
);

	import crc5_pkg::*;

	crc_byte_t byte_q;
	crc5_t     crc_q;
	crc5_t     crc_d;
	bit_idx_t  sel_idx;
	logic      data_bit;
	logic      feedback;

	always_ff @(posedge i_sys_clk)
	begin
		if (step.load)
			byte_q <= i_data;
	end

	// Index 0 of the count picks bit 7, so bits leave MSB first
	assign sel_idx  = ~step.bit_idx;
	assign data_bit = byte_q[sel_idx];
	assign feedback = data_bit ^ crc_q[CRC5_WIDTH-1];

	always_comb
	begin
		crc_d = {crc_q[CRC5_WIDTH-2:0], 1'b0};
		if (feedback)
			crc_d = crc_d ^ CRC5_POLY;
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			crc_q <= CRC5_SEED;
		else if (!i_en || step.restart)
			crc_q <= CRC5_SEED;
		else if (step.shift)
			crc_q <= crc_d;
	end

	assign o_remainder = crc_q;

	// Each byte must be fully shifted before the register is reseeded by a report
	property p_byte_done;
		@(posedge i_sys_clk) disable iff (!i_sys_rst || !i_en)
			step.load |=> (!step.restart)[*BYTE_BITS];
	endproperty

	a_byte_done: assert property (p_byte_done)
		else $error("Reseed during byte shift");

endmodule

/* logic/crc5_step_if.sv */
`timescale 1ns/1ps

interface crc5_step_if;

	import crc5_pkg::*;

	logic     load;                                 // Capture byte, clear count
	logic     shift;                                // High for the eight shift cycles
	logic     restart;                              // Reseed the CRC register
	bit_idx_t bit_idx;
	logic     last_bit;

	modport ctrl
	(
		output load,
		output shift,
		output restart,
		input  last_bit
	);

	modport cnt
	(
		input  load,
		input  shift,
		output bit_idx,
		output last_bit
	);

	modport shf
	(
		input load,
		input shift,
		input restart,
		input bit_idx,
		input last_bit
	);

endinterface
